// File: all.f
hdl/raster_pkg.sv
hdl/raster_prim_if.sv
hdl/raster_quad_if.sv
hdl/raster_dcr.sv
hdl/raster_fetch.sv
hdl/raster_setup.sv
hdl/raster_slice.sv
hdl/raster_quad_arb.sv
hdl/raster_unit.sv
verif/raster_mem_model.sv
verif/raster_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = raster_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -x 'TEST OK' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: verif/raster_tb.sv
`default_nettype none

module raster_tb import raster_pkg::*; ;

    localparam int num_slices      = 2;
    localparam int tile_logsize    = 4;
    localparam int mem_fifo_depth  = 4;
    localparam int tile_size       = 1 << tile_logsize;
    localparam int quads_per_side  = tile_size / 2;
    localparam int quads_per_tile  = quads_per_side * quads_per_side;
    localparam int run_limit       = 3000;                  // cycles per run
    localparam int max_cycles      = 6 * (run_limit + 50);  // six tests

    logic                     clk = 1'b0;
    logic                     reset = 1'b1;
    logic                     dcr_write_valid = 1'b0;
    logic [dcr_addr_bits-1:0] dcr_write_addr = '0;
    logic [word_bits-1:0]     dcr_write_data = '0;
    logic                     mem_req_valid;
    logic [addr_bits-1:0]     mem_req_addr;
    logic                     mem_req_ready;
    logic                     mem_rsp_valid;
    logic [word_bits-1:0]     mem_rsp_data;
    logic                     quad_valid;
    logic [dim_bits-1:0]      quad_x;
    logic [dim_bits-1:0]      quad_y;
    logic [3:0]               quad_mask;
    logic [pid_bits-1:0]      quad_pid;
    logic                     quad_empty;
    logic                     quad_ready = 1'b1;
    logic [1:0]               rsp_delay = 2'd0;

    logic [31:0]    lfsr = 32'hb011;
    logic           random_ready = 1'b0;
    string          test_name = "reset";
    int             checks = 0;
    int             errors_value = 0;
    int             errors_other = 0;
    int             cycle_count = 0;
    int             empty_seen = 0;
    int             req_seen = 0;
    logic [31:0]    req_lo = '0;      // allowed request window
    logic [31:0]    req_hi = '0;
    int             tile_x_of [256];
    int             tile_y_of [256];
    edges_t         prim_edges [256];
    bit             loaded [256];
    bit             seen [256][quads_per_tile];
    int             got [256];
    int             pids [$];         // primitives of the current run

    raster_unit #(
        .num_slices(num_slices), .tile_logsize(tile_logsize), .mem_fifo_depth(mem_fifo_depth)
    ) UUT (
        .clk, .reset, .dcr_write_valid, .dcr_write_addr, .dcr_write_data,
        .mem_req_valid, .mem_req_addr, .mem_req_ready, .mem_rsp_valid, .mem_rsp_data,
        .quad_valid, .quad_x, .quad_y, .quad_mask, .quad_pid, .quad_empty, .quad_ready
    );

    raster_mem_model mem_model (
        .clk, .reset,
        .req_valid (mem_req_valid),
        .req_addr  (mem_req_addr),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp_data  (mem_rsp_data),
        .delay     (rsp_delay)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    ////////////////////////////////////////
    // reference model of the coverage rule

    function automatic logic [3:0] expected_mask(input int pid, input int x, input int y);
        logic [3:0] m;
        longint     v;
        m = 4'hf;
        for (int p = 0; p < 4; p++) begin
            for (int e = 0; e < 3; e++) begin
                v = longint'($signed(prim_edges[pid][e].a)) * (x + p % 2)
                  + longint'($signed(prim_edges[pid][e].b)) * (y + p / 2)
                  + longint'($signed(prim_edges[pid][e].c));
                if (v < 0) m[p] = 1'b0;
            end
        end
        return m;
    endfunction

    function automatic int expected_quads(input int pid);
        int n;
        n = 0;
        for (int qy = 0; qy < quads_per_side; qy++) begin
            for (int qx = 0; qx < quads_per_side; qx++) begin
                if (expected_mask(pid, tile_x_of[pid] * tile_size + 2 * qx,
                                  tile_y_of[pid] * tile_size + 2 * qy) != 4'h0) n++;
            end
        end
        return n;
    endfunction

    function automatic edges_t make_edges(input int a0, b0, c0, a1, b1, c1, a2, b2, c2);
        edges_t e;
        e[0] = '{a0, b0, c0};
        e[1] = '{a1, b1, c1};
        e[2] = '{a2, b2, c2};
        return e;
    endfunction

    task check(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors_value++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, expected,
                     actual);
        end
    endtask

    task print_summary;
        $display("checks %0d, mismatches %0d, other errors %0d", checks, errors_value,
                 errors_other);
    endtask

    ////////////////////////////////////////
    // stimulus and monitors

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles in %s", cycle_count, test_name);
            print_summary();
            $display("TEST FAILED");
            $finish;
        end
    end

    // response delays and output back-pressure
    always @(posedge clk) begin
        #1;
        lfsr = lfsr_step(lfsr);
        rsp_delay[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        rsp_delay[1] = lfsr[0];
        if (random_ready) begin
            lfsr = lfsr_step(lfsr);
            quad_ready = lfsr[0];
        end else begin
            quad_ready = 1'b1;
        end
    end

    task automatic record_quad;
        int pid;
        int ox;
        int oy;
        int qi;
        pid = int'(quad_pid);
        ox = tile_x_of[pid] * tile_size;
        oy = tile_y_of[pid] * tile_size;
        if (!loaded[pid] || int'(quad_x) < ox || int'(quad_x) >= ox + tile_size
                || int'(quad_y) < oy || int'(quad_y) >= oy + tile_size
                || quad_x[0] || quad_y[0]) begin
            errors_other++;
            $display("%s: quad at (%0d, %0d) lies outside the tile of pid %0d",
                     test_name, quad_x, quad_y, pid);
        end else begin
            qi = (int'(quad_y) - oy) / 2 * quads_per_side + (int'(quad_x) - ox) / 2;
            if (seen[pid][qi]) begin
                errors_other++;
                $display("%s: quad at (%0d, %0d) of pid %0d arrived twice",
                         test_name, quad_x, quad_y, pid);
            end
            seen[pid][qi] = 1'b1;
            got[pid]++;
            check("quad_mask", int'(expected_mask(pid, int'(quad_x), int'(quad_y))),
                  int'(quad_mask));
        end
    endtask

    always @(negedge clk) begin
        if (!reset && mem_req_valid && mem_req_ready) begin
            req_seen++;
            check("req_in_window", 1, int'(mem_req_addr >= req_lo && mem_req_addr < req_hi));
        end
        if (!reset && quad_valid && quad_ready) begin
            if (quad_empty) begin
                empty_seen++;
                check("empty_mask", 0, int'(quad_mask));
            end else begin
                record_quad();
            end
        end
    end

    ////////////////////////////////////////
    // tasks used by the tests

    task dcr_write(input logic [dcr_addr_bits-1:0] addr, input logic [word_bits-1:0] data);
        @(posedge clk);
        #1;
        dcr_write_valid = 1'b1;
        dcr_write_addr  = addr;
        dcr_write_data  = data;
        @(posedge clk);
        #1;
        dcr_write_valid = 1'b0;
    endtask

    task load_prim(input logic [31:0] addr, input int pid, input int tx, input int ty,
                   input edges_t e);
        mem_model.write_word(addr, {16'(ty), 16'(tx)});
        mem_model.write_word(addr + 32'd1, 32'(pid));
        for (int i = 0; i < 3; i++) begin
            mem_model.write_word(addr + 32'(2 + 3 * i), e[i].a);
            mem_model.write_word(addr + 32'(3 + 3 * i), e[i].b);
            mem_model.write_word(addr + 32'(4 + 3 * i), e[i].c);
        end
        tile_x_of[pid]  = tx;
        tile_y_of[pid]  = ty;
        prim_edges[pid] = e;
        loaded[pid]     = 1'b1;
        got[pid]        = 0;
        for (int q = 0; q < quads_per_tile; q++) seen[pid][q] = 1'b0;
        pids.push_back(pid);
    endtask

    task run_and_collect(input logic [31:0] base, input logic [31:0] count);
        int empties_before;
        int reqs_before;
        int waited;
        empties_before = empty_seen;
        reqs_before    = req_seen;
        req_lo         = base;
        req_hi         = base + count * 32'(prim_words);
        dcr_write(dcr_prim_base, base);
        dcr_write(dcr_prim_count, count);
        waited = 0;
        while (empty_seen == empties_before && waited < run_limit) begin
            @(posedge clk);
            waited++;
        end
        if (empty_seen == empties_before) begin
            errors_other++;
            $display("%s: no empty transfer within %0d cycles", test_name, run_limit);
        end
        repeat (20) @(posedge clk);     // a stray second empty would show here
        check("empty_count", 1, empty_seen - empties_before);
        check("mem_requests", int'(count) * prim_words, req_seen - reqs_before);
        foreach (pids[i]) check("quad_count", expected_quads(pids[i]), got[pids[i]]);
        pids.delete();
    endtask

    task load_five(input logic [31:0] base);
        load_prim(base,          11, 0, 0, make_edges(1, 0, -3, 0, 1, -2, -1, -1, 20));
        load_prim(base + 32'd11, 12, 3, 1, make_edges(1, -1, -30, 0, 0, 1, 0, 0, 1));
        load_prim(base + 32'd22, 13, 5, 5, make_edges(-2, 1, 90, 0, 1, -82, 0, 0, 1));
        load_prim(base + 32'd33, 14, 2, 7, make_edges(0, 0, -1, 0, 0, 1, 0, 0, 1));
        load_prim(base + 32'd44, 15, 1, 2, make_edges(0, 0, 1, 0, 0, 1, 0, 0, 1));
    endtask

    ////////////////////////////////////////
    // tests

    task idle_after_reset;
        test_name = "idle_after_reset";
        repeat (20) begin
            @(negedge clk);
            check("quad_valid", 0, int'(quad_valid));
            check("mem_req_valid", 0, int'(mem_req_valid));
        end
    endtask

    task full_tile;
        test_name = "full_tile";
        load_prim(32'd16, 1, 1, 2, make_edges(0, 0, 1, 0, 0, 1, 0, 0, 1));
        run_and_collect(32'd16, 32'd1);
        check("full_count", 64, got[1]);
    endtask

    task half_plane;
        test_name = "half_plane";
        load_prim(32'd40, 2, 2, 1, make_edges(1, -1, -15, 0, 0, 1, 0, 0, 1));  // diagonal
        run_and_collect(32'd40, 32'd1);
    endtask

    task multi_slice;
        test_name    = "multi_slice";
        random_ready = 1'b1;
        load_five(32'd200);
        run_and_collect(32'd200, 32'd5);
        random_ready = 1'b0;
    endtask

    task zero_count;
        test_name = "zero_count";
        run_and_collect(32'd500, 32'd0);
    endtask

    task rerun;
        test_name    = "rerun";
        random_ready = 1'b1;
        load_five(32'd600);
        run_and_collect(32'd600, 32'd5);
        random_ready = 1'b0;
    endtask

    initial begin
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        idle_after_reset();
        full_tile();
        half_plane();
        multi_slice();
        zero_count();
        rerun();
        print_summary();
        if (errors_value + errors_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/raster_mem_model.sv
`default_nettype none

module raster_mem_model import raster_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  req_valid,
    input  wire [addr_bits-1:0]  req_addr,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output logic [word_bits-1:0] rsp_data,
    input  wire [1:0]            delay      // extra cycles for the next response
);

    logic [word_bits-1:0] mem [mem_words];
    logic [word_bits-1:0] data_q [$];
    int                   due_q [$];      // cycle at which each response is driven
    int                   cyc = 0;
    int                   last_due = 0;
    int                   due;

    initial begin
        req_ready = 1'b1;
        rsp_valid = 1'b0;
        rsp_data  = '0;
    end

    task write_word(input logic [addr_bits-1:0] addr, input logic [word_bits-1:0] data);
        mem[int'(addr % addr_bits'(mem_words))] = data;
    endtask

    // accept requests, keep responses in order, one per cycle at most
    always @(negedge clk) begin
        if (reset) begin
            data_q.delete();
            due_q.delete();
            last_due = cyc;
        end else if (req_valid && req_ready) begin
            due = cyc + 1 + int'(delay);
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            data_q.push_back(mem[int'(req_addr % addr_bits'(mem_words))]);
            due_q.push_back(due);
        end
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        #1;
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            rsp_valid = 1'b1;
            rsp_data  = data_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            rsp_valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_unit.sv
`default_nettype none

module raster_unit import raster_pkg::*; #(
    parameter int num_slices     = 2,
    parameter int tile_logsize   = 4,
    parameter int mem_fifo_depth = 4
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     dcr_write_valid,
    input  wire [dcr_addr_bits-1:0] dcr_write_addr,
    input  wire [word_bits-1:0]     dcr_write_data,
    output logic                    mem_req_valid,
    output logic [addr_bits-1:0]    mem_req_addr,
    input  wire                     mem_req_ready,
    input  wire                     mem_rsp_valid,
    input  wire [word_bits-1:0]     mem_rsp_data,
    output logic                    quad_valid,
    output logic [dim_bits-1:0]     quad_x,
    output logic [dim_bits-1:0]     quad_y,
    output logic [3:0]              quad_mask,
    output logic [pid_bits-1:0]     quad_pid,
    output logic                    quad_empty,
    input  wire                     quad_ready
);

    logic [addr_bits-1:0]  prim_base;
    logic [word_bits-1:0]  prim_count;
    logic                  start;
    logic                  fetch_busy;
    logic                  setup_busy;
    logic [num_slices-1:0] slice_idle;

    raster_prim_if fetch_prim ();
    raster_prim_if slice_prim [num_slices] ();
    raster_quad_if slice_quad [num_slices] ();

    raster_dcr raster_dcr (
        .clk, .reset, .dcr_write_valid, .dcr_write_addr, .dcr_write_data,
        .prim_base, .prim_count, .start
    );

    raster_fetch #(.mem_fifo_depth(mem_fifo_depth)) raster_fetch (
        .clk, .reset, .start, .prim_base, .prim_count,
        .mem_req_valid, .mem_req_addr, .mem_req_ready, .mem_rsp_valid, .mem_rsp_data,
        .busy (fetch_busy),
        .prim (fetch_prim)
    );

    raster_setup #(.num_slices(num_slices), .tile_logsize(tile_logsize)) raster_setup (
        .clk, .reset, .fetch_busy,
        .prim_in  (fetch_prim),
        .prim_out (slice_prim),
        .busy     (setup_busy)
    );

    for (genvar i = 0; i < num_slices; i++) begin : g_slice
        raster_slice #(.tile_logsize(tile_logsize)) raster_slice (
            .clk, .reset,
            .prim (slice_prim[i]),
            .quad (slice_quad[i]),
            .idle (slice_idle[i])
        );
    end

    raster_quad_arb #(.num_slices(num_slices)) raster_quad_arb (
        .clk, .reset, .start, .setup_busy, .slice_idle,
        .quad_in (slice_quad),
        .quad_valid, .quad_x, .quad_y, .quad_mask, .quad_pid, .quad_empty, .quad_ready
    );

endmodule

`default_nettype wire

// File: hdl/raster_quad_arb.sv
`default_nettype none

module raster_quad_arb import raster_pkg::*; #(
    parameter int num_slices = 2
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  wire                   setup_busy,
    input  wire [num_slices-1:0]  slice_idle,
    raster_quad_if.dst            quad_in [num_slices],
    output logic                  quad_valid,
    output logic [dim_bits-1:0]   quad_x,
    output logic [dim_bits-1:0]   quad_y,
    output logic [3:0]            quad_mask,
    output logic [pid_bits-1:0]   quad_pid,
    output logic                  quad_empty,
    input  wire                   quad_ready
);

    localparam int sel_bits = (num_slices > 1) ? $clog2(num_slices) : 1;

    logic [num_slices-1:0] in_valid;
    logic [dim_bits-1:0]   in_x    [num_slices];
    logic [dim_bits-1:0]   in_y    [num_slices];
    logic [3:0]            in_mask [num_slices];
    logic [pid_bits-1:0]   in_pid  [num_slices];
    logic [sel_bits-1:0]   last;
    logic [sel_bits-1:0]   pick;
    logic                  armed;   // one empty transfer owed

    wire out_free   = !quad_valid || quad_ready;
    wire take       = out_free && in_valid[pick];
    wire drained    = !setup_busy && (&slice_idle) && !(|in_valid);
    wire send_empty = armed && drained && out_free;

    for (genvar i = 0; i < num_slices; i++) begin : g_in
        assign in_valid[i]      = quad_in[i].valid;
        assign in_x[i]          = quad_in[i].x;
        assign in_y[i]          = quad_in[i].y;
        assign in_mask[i]       = quad_in[i].mask;
        assign in_pid[i]        = quad_in[i].pid;
        assign quad_in[i].ready = out_free && (pick == sel_bits'(i));
    end

    always_comb begin
        int idx;
        pick = last;
        for (int k = num_slices; k >= 1; k--) begin
            idx = (int'(last) + k) % num_slices;
            if (in_valid[idx]) pick = sel_bits'(idx);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            quad_valid <= 1'b0;
            quad_empty <= 1'b0;
            armed      <= 1'b0;
            last       <= sel_bits'(num_slices - 1);
        end else begin
            if (start) armed <= 1'b1;
            else if (send_empty) armed <= 1'b0;
            if (take || send_empty) quad_valid <= 1'b1;
            else if (quad_ready) quad_valid <= 1'b0;
            if (take) begin
                quad_empty <= 1'b0;
                last       <= pick;     // rotate
            end else if (send_empty) begin
                quad_empty <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            quad_x    <= in_x[pick];
            quad_y    <= in_y[pick];
            quad_mask <= in_mask[pick];
            quad_pid  <= in_pid[pick];
        end else if (send_empty) begin
            quad_mask <= 4'h0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_slice.sv
`default_nettype none

module raster_slice import raster_pkg::*; #(
    parameter int tile_logsize = 4
) (
    input  wire        clk,
    input  wire        reset,
    raster_prim_if.dst prim,
    raster_quad_if.src quad,
    output logic       idle
);

    localparam int qbits = tile_logsize - 1;   // quads per tile side, log2

    logic                        active;
    logic [qbits-1:0]            qx;
    logic [qbits-1:0]            qy;
    logic [dim_bits-1:0]         org_x;
    logic [dim_bits-1:0]         org_y;
    logic [pid_bits-1:0]         pid_r;
    logic signed [data_bits-1:0] a_r   [3];
    logic signed [data_bits-1:0] b_r   [3];
    logic signed [data_bits-1:0] row_v [3];  // value at the row's first quad
    logic signed [data_bits-1:0] cur_v [3];  // value at the current quad
    logic signed [data_bits-1:0] v     [4];
    logic [3:0]                  mask;

    wire prim_fire = prim.valid && prim.ready;
    wire hold      = quad.valid && !quad.ready;
    wire step      = active && !hold;
    wire last_col  = (qx == '1);
    wire last_row  = (qy == '1);

    assign prim.ready = !active;
    assign idle       = !active;

    ////////////////////////////////////////
    // coverage of the current quad

    always_comb begin
        mask = 4'hf;
        for (int e = 0; e < 3; e++) begin
            v[0] = cur_v[e];
            v[1] = cur_v[e] + a_r[e];
            v[2] = cur_v[e] + b_r[e];
            v[3] = cur_v[e] + a_r[e] + b_r[e];
            for (int p = 0; p < 4; p++) begin
                if (v[p][data_bits-1]) mask[p] = 1'b0;  // negative, outside
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            qx         <= '0;
            qy         <= '0;
            quad.valid <= 1'b0;
        end else begin
            if (prim_fire) begin
                active <= 1'b1;
                qx     <= '0;
                qy     <= '0;
            end else if (step) begin
                qx <= qx + 1'b1;        // wraps at row end
                if (last_col) begin
                    qy <= qy + 1'b1;
                    if (last_row) active <= 1'b0;
                end
            end
            if (step && mask != 4'h0) quad.valid <= 1'b1;
            else if (quad.ready) quad.valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // incremental edge stepping

    always_ff @(posedge clk) begin
        if (prim_fire) begin
            org_x <= prim.tile_x[dim_bits-1:0];
            org_y <= prim.tile_y[dim_bits-1:0];
            pid_r <= prim.pid;
        end
        for (int e = 0; e < 3; e++) begin
            if (prim_fire) begin
                a_r[e]   <= prim.edges[e].a;
                b_r[e]   <= prim.edges[e].b;
                row_v[e] <= prim.edges[e].c;
                cur_v[e] <= prim.edges[e].c;
            end else if (step) begin
                if (last_col) begin
                    row_v[e] <= row_v[e] + (b_r[e] <<< 1);
                    cur_v[e] <= row_v[e] + (b_r[e] <<< 1);
                end else begin
                    cur_v[e] <= cur_v[e] + (a_r[e] <<< 1);   // two pixels right
                end
            end
        end
        if (step && mask != 4'h0) begin
            quad.x    <= org_x + dim_bits'({qx, 1'b0});
            quad.y    <= org_y + dim_bits'({qy, 1'b0});
            quad.mask <= mask;
            quad.pid  <= pid_r;
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_setup.sv
`default_nettype none

module raster_setup import raster_pkg::*; #(
    parameter int num_slices   = 2,
    parameter int tile_logsize = 4
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        fetch_busy,
    raster_prim_if.dst prim_in,
    raster_prim_if.src prim_out [num_slices],
    output logic       busy
);

    localparam int sel_bits = (num_slices > 1) ? $clog2(num_slices) : 1;

    logic                        stage_valid;
    logic [sel_bits-1:0]         sel;           // target slice, also rr pointer
    logic [sel_bits-1:0]         pick;
    logic [num_slices-1:0]       slice_ready;
    logic [num_slices-1:0]       slice_free;
    logic [pid_bits-1:0]         st_pid;
    logic [tile_bits-1:0]        st_x;
    logic [tile_bits-1:0]        st_y;
    edges_t                      st_edges;
    edges_t                      edges_eval;
    logic signed [data_bits-1:0] org_x;
    logic signed [data_bits-1:0] org_y;

    wire stage_ready = !stage_valid || slice_ready[sel];

    assign prim_in.ready = stage_ready;
    assign busy          = stage_valid || fetch_busy;

    assign org_x = data_bits'(prim_in.tile_x) << tile_logsize;
    assign org_y = data_bits'(prim_in.tile_y) << tile_logsize;

    always_comb begin
        for (int e = 0; e < 3; e++) begin
            edges_eval[e]   = prim_in.edges[e];
            edges_eval[e].c = prim_in.edges[e].a * org_x + prim_in.edges[e].b * org_y
                            + prim_in.edges[e].c;   // value at the tile origin
        end
    end

    // nearest free slice after the last one picked
    always_comb begin
        int idx;
        pick = sel_bits'((int'(sel) + 1) % num_slices);
        for (int k = num_slices; k >= 1; k--) begin
            idx = (int'(sel) + k) % num_slices;
            if (slice_free[idx]) pick = sel_bits'(idx);
        end
    end

    for (genvar i = 0; i < num_slices; i++) begin : g_out
        assign prim_out[i].valid  = stage_valid && (sel == sel_bits'(i));
        assign prim_out[i].pid    = st_pid;
        assign prim_out[i].tile_x = st_x;
        assign prim_out[i].tile_y = st_y;
        assign prim_out[i].edges  = st_edges;
        assign slice_ready[i]     = prim_out[i].ready;
        assign slice_free[i]      = slice_ready[i] && !(stage_valid && sel == sel_bits'(i));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
            sel         <= sel_bits'(num_slices - 1);
        end else if (stage_ready) begin
            stage_valid <= prim_in.valid;
            if (prim_in.valid) sel <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_ready && prim_in.valid) begin
            st_pid   <= prim_in.pid;
            st_x     <= tile_bits'(org_x);
            st_y     <= tile_bits'(org_y);
            st_edges <= edges_eval;
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_fetch.sv
`default_nettype none

module raster_fetch import raster_pkg::*; #(
    parameter int mem_fifo_depth = 4
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  start,
    input  wire [addr_bits-1:0]  prim_base,
    input  wire [word_bits-1:0]  prim_count,
    output logic                 mem_req_valid,
    output logic [addr_bits-1:0] mem_req_addr,
    input  wire                  mem_req_ready,
    input  wire                  mem_rsp_valid,
    input  wire [word_bits-1:0]  mem_rsp_data,
    output logic                 busy,
    raster_prim_if.src           prim
);

    localparam int ptr_bits = (mem_fifo_depth > 1) ? $clog2(mem_fifo_depth) : 1;
    localparam int cnt_bits = $clog2(mem_fifo_depth + 1);

    logic [addr_bits-1:0] req_left;     // words still to request
    logic [cnt_bits-1:0]  pending;      // requested but not yet consumed
    logic [word_bits-1:0] q_mem [mem_fifo_depth];
    logic [ptr_bits-1:0]  q_wr;
    logic [ptr_bits-1:0]  q_rd;
    logic [cnt_bits-1:0]  q_cnt;
    logic [3:0]           word_idx;
    logic [word_bits-1:0] prim_done;

    wire q_empty   = (q_cnt == '0);
    wire req_fire  = mem_req_valid && mem_req_ready;
    wire prim_fire = prim.valid && prim.ready;
    wire pop       = !prim.valid && (!q_empty || mem_rsp_valid);
    wire q_push    = mem_rsp_valid && !(pop && q_empty);   // bypass when empty
    wire q_pop     = pop && !q_empty;
    wire [word_bits-1:0] pop_data = q_empty ? mem_rsp_data : q_mem[q_rd];

    assign mem_req_valid = busy && (req_left != '0) && (pending < cnt_bits'(mem_fifo_depth));

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            req_left   <= '0;
            pending    <= '0;
            q_wr       <= '0;
            q_rd       <= '0;
            q_cnt      <= '0;
            word_idx   <= '0;
            prim_done  <= '0;
            prim.valid <= 1'b0;
        end else begin
            if (start && prim_count != '0) begin
                busy      <= 1'b1;
                req_left  <= addr_bits'(prim_count) * addr_bits'(prim_words);
                prim_done <= '0;
            end else begin
                if (req_fire) req_left <= req_left - 1'b1;
                if (prim_fire) begin
                    prim_done <= prim_done + 1'b1;
                    if (prim_done + word_bits'(1) == prim_count) busy <= 1'b0;
                end
            end
            pending <= pending + cnt_bits'(req_fire) - cnt_bits'(pop);
            q_cnt   <= q_cnt + cnt_bits'(q_push) - cnt_bits'(q_pop);
            if (q_push) q_wr <= (q_wr == ptr_bits'(mem_fifo_depth - 1)) ? '0 : q_wr + 1'b1;
            if (q_pop) q_rd <= (q_rd == ptr_bits'(mem_fifo_depth - 1)) ? '0 : q_rd + 1'b1;
            if (pop) word_idx <= (word_idx == 4'(prim_words - 1)) ? '0 : word_idx + 1'b1;
            if (pop && word_idx == 4'(prim_words - 1)) prim.valid <= 1'b1;
            else if (prim_fire) prim.valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // response queue and record assembly

    always_ff @(posedge clk) begin
        if (start) mem_req_addr <= prim_base;
        else if (req_fire) mem_req_addr <= mem_req_addr + 1'b1;
        if (q_push) q_mem[q_wr] <= mem_rsp_data;
        if (pop) begin
            case (word_idx)
                4'd0:    {prim.tile_y, prim.tile_x} <= pop_data;
                4'd1:    prim.pid <= pop_data[pid_bits-1:0];
                4'd2:    prim.edges[0].a <= pop_data;
                4'd3:    prim.edges[0].b <= pop_data;
                4'd4:    prim.edges[0].c <= pop_data;
                4'd5:    prim.edges[1].a <= pop_data;
                4'd6:    prim.edges[1].b <= pop_data;
                4'd7:    prim.edges[1].c <= pop_data;
                4'd8:    prim.edges[2].a <= pop_data;
                4'd9:    prim.edges[2].b <= pop_data;
                default: prim.edges[2].c <= pop_data;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_dcr.sv
`default_nettype none

module raster_dcr import raster_pkg::*; (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     dcr_write_valid,
    input  wire [dcr_addr_bits-1:0] dcr_write_addr,
    input  wire [word_bits-1:0]     dcr_write_data,
    output logic [addr_bits-1:0]    prim_base,
    output logic [word_bits-1:0]    prim_count,
    output logic                    start
);

    always_ff @(posedge clk) begin
        if (reset) begin
            prim_base  <= '0;
            prim_count <= '0;
            start      <= 1'b0;
        end else begin
            start <= 1'b0;
            if (dcr_write_valid) begin
                case (dcr_write_addr)
                    dcr_prim_base: begin
                        prim_base <= dcr_write_data;
                    end
                    dcr_prim_count: begin
                        prim_count <= dcr_write_data;
                        start      <= 1'b1; // kick off a run
                    end
                    default: ;              // unmapped
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/raster_quad_if.sv
`default_nettype none

interface raster_quad_if import raster_pkg::*; ();

    logic                valid;
    logic                ready;
    logic [dim_bits-1:0] x;
    logic [dim_bits-1:0] y;
    logic [3:0]          mask;  // {x+1 y+1, x y+1, x+1 y, x y}
    logic [pid_bits-1:0] pid;

    modport src (
        output valid, x, y, mask, pid,
        input  ready
    );

    modport dst (
        input  valid, x, y, mask, pid,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/raster_prim_if.sv
`default_nettype none

interface raster_prim_if import raster_pkg::*; ();

    logic                 valid;
    logic                 ready;
    logic [pid_bits-1:0]  pid;
    logic [tile_bits-1:0] tile_x;   // tile index, or pixel origin after setup
    logic [tile_bits-1:0] tile_y;
    edges_t               edges;

    modport src (
        output valid, pid, tile_x, tile_y, edges,
        input  ready
    );

    modport dst (
        input  valid, pid, tile_x, tile_y, edges,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/raster_pkg.sv
`default_nettype none

package raster_pkg;

    ////////////////////////////////////////
    // widths

    localparam int dim_bits      = 11;
    localparam int tile_bits     = 16;
    localparam int pid_bits      = 8;
    localparam int data_bits     = 32;
    localparam int word_bits     = 32;
    localparam int addr_bits     = 32;
    localparam int dcr_addr_bits = 4;

    ////////////////////////////////////////
    // DCR map

    localparam logic [dcr_addr_bits-1:0] dcr_prim_base  = 4'd0;
    localparam logic [dcr_addr_bits-1:0] dcr_prim_count = 4'd1; // write starts a run

    // record: {tile_y, tile_x}, pid, then a/b/c of edges 0..2
    localparam int prim_words = 11;

    ////////////////////////////////////////
    // edge equations

    typedef struct packed {
        logic signed [data_bits-1:0] a;
        logic signed [data_bits-1:0] b;
        logic signed [data_bits-1:0] c;
    } edge_t;

    typedef edge_t [2:0] edges_t;

endpackage

`default_nettype wire
